// File: Bender.yml
package:
  name: eth_frame_matcher

sources:
  - hdl/efm_geom_pkg.sv
  - hdl/efm_op_pkg.sv
  - hdl/frame_ctrl.sv
  - hdl/pattern_ram.sv
  - hdl/lane_engine.sv
  - hdl/field_extractor.sv
  - hdl/byte_rewriter.sv
  - hdl/eth_frame_matcher.sv
  - target: test
    files:
      - dv/eth_frame_matcher_props.sv
      - dv/tb_eth_frame_matcher.sv

// File: dv/eth_frame_matcher_props.sv
// Stream timing and result stability properties of the frame matcher, bound to its top level
`timescale 1ns/10ps

module eth_frame_matcher_props (
	input logic       s_axis_clk,
	input logic       rst_n_cdc,
	input logic       s_axis_tvalid,
	input logic       s_axis_tlast,
	input logic       m_axis_tvalid,
	input logic       m_axis_tlast,
	input logic [1:0] m_axis_tuser,
	input logic [1:0] match_id
);

	int fail_count = 0;

	// Beat sampled at edge t is seen on m_axis at edge t+2
	a_valid_latency: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		m_axis_tvalid == $past(s_axis_tvalid, 2))
	else begin
		$error("m_axis_tvalid does not follow s_axis_tvalid after two cycles");
		fail_count++;
	end

	a_last_latency: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		m_axis_tlast == $past(s_axis_tlast, 2))
	else begin
		$error("m_axis_tlast does not follow s_axis_tlast after two cycles");
		fail_count++;
	end

	// Results move only at edge t+3 after a last beat
	a_id_update: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		$changed(match_id) |-> $past(s_axis_tvalid && s_axis_tlast, 3))
	else begin
		$error("match_id changed without a last beat three cycles earlier");
		fail_count++;
	end

	a_mod_sticky: assert property (@(posedge s_axis_clk) disable iff (!rst_n_cdc)
		$fell(m_axis_tuser[1]) |-> $past(m_axis_tvalid && m_axis_tlast))
	else begin
		$error("m_axis_tuser[1] fell in the middle of a frame");
		fail_count++;
	end

endmodule

bind eth_frame_matcher eth_frame_matcher_props u_props (
	.s_axis_clk    (s_axis_clk),
	.rst_n_cdc     (rst_n_cdc),
	.s_axis_tvalid (s_axis_tvalid),
	.s_axis_tlast  (s_axis_tlast),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tlast  (m_axis_tlast),
	.m_axis_tuser  (m_axis_tuser),
	.match_id      (match_id)
);

// File: dv/tb_eth_frame_matcher.sv
// Testbench of the frame matcher: loads patterns, drives frames and checks a byte-level model
`timescale 1ns/10ps

module tb_eth_frame_matcher
	import efm_geom_pkg::*;
();

	logic s_axis_clk;
	logic rst_n_cdc;
	logic [7:0] s_axis_tdata;
	logic s_axis_tuser;
	logic s_axis_tlast;
	logic s_axis_tvalid;
	logic [7:0] m_axis_tdata;
	logic [1:0] m_axis_tuser;
	logic m_axis_tlast;
	logic m_axis_tvalid;
	logic cfg_we;
	logic [PAT_AW-1:0] cfg_addr;
	logic [PAT_W-1:0] cfg_data;
	logic [PAT_W-1:0] cfg_flags;
	logic [NUM_LANES-1:0] match_en;
	logic [NUM_LANES-1:0] match;
	logic [1:0] match_id;
	logic [EXT_NUM_W-1:0] match_ext_num;
	logic [EXT_DATA_W-1:0] match_ext_data;

	// Reference model state
	logic [PAT_W-1:0] ref_data [PAT_DEPTH];
	logic [PAT_W-1:0] ref_flags [PAT_DEPTH];
	logic [7:0] ref_lfsr;
	logic [10:0] exp_q [$];
	logic [7:0] frm [$];
	logic [7:0] golden [$];
	logic [NUM_LANES-1:0] exp_match;
	logic [1:0] exp_id;
	logic [EXT_NUM_W-1:0] exp_ext_num;
	logic [EXT_DATA_W-1:0] exp_ext_data;
	logic hit_seen;

	eth_frame_matcher DUT (.*);

	initial s_axis_clk = 1'b0;
	always #10 s_axis_clk = ~s_axis_clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [7:0] flag_bit(input int pos);
		return 8'(1 << pos);
	endfunction

	function automatic logic [7:0] lfsr_next(input logic [7:0] v);
		return {v[6:0], v[7] ^ v[5] ^ v[4] ^ v[3]};
	endfunction

	task automatic write_entry(input int addr);
		@(posedge s_axis_clk);
		cfg_we <= 1'b1;
		cfg_addr <= PAT_AW'(addr);
		cfg_data <= ref_data[addr];
		cfg_flags <= ref_flags[addr];
		@(posedge s_axis_clk);
		cfg_we <= 1'b0;
	endtask

	task automatic set_lane(input int addr, input int lane, input logic [7:0] data,
		input logic [7:0] flags);
		ref_data[addr][8*lane +: 8] = data;
		ref_flags[addr][8*lane +: 8] = flags;
		write_entry(addr);
	endtask

	task automatic random_frame(input int len);
		frm.delete();
		for (int i = 0; i < len; i++) begin
			frm.push_back(8'($urandom));
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			@(posedge s_axis_clk);
			n++;
			if (n > 200) begin
				abort_run("Timeout: expected output beats never appeared on m_axis");
			end
		end
	endtask

	task automatic check_results();
		assert (match == exp_match && match_id == exp_id && match_ext_num == exp_ext_num)
		else abort_run($sformatf("FAIL @ %0t: match %b id %0d num %0d, expected %b %0d %0d",
			$time, match, match_id, match_ext_num, exp_match, exp_id, exp_ext_num));
		if (hit_seen) begin
			assert (match_ext_data == exp_ext_data)
			else abort_run($sformatf("FAIL @ %0t: match_ext_data %h, expected %h",
				$time, match_ext_data, exp_ext_data));
		end
	endtask

	// Model the whole frame, then drive it and check the results
	task automatic send_frame(input logic [NUM_LANES-1:0] en);
		logic [NUM_LANES-1:0] alive;
		logic [1:0] carry [NUM_LANES];
		logic [EXT_DATA_W-1:0] ext_buf;
		logic [7:0] pb;
		logic [7:0] pf;
		logic [7:0] opnd;
		logic [7:0] outb;
		logic [9:0] sum;
		logic is_add;
		logic took;
		logic want_ext;
		logic sticky;
		logic last;
		int ext_cnt;
		alive = '1;
		ext_buf = '0;
		ext_cnt = 0;
		sticky = 1'b0;
		for (int l = 0; l < NUM_LANES; l++) begin
			carry[l] = 2'b00;
		end
		for (int i = 0; i < frm.size(); i++) begin
			last = (i == frm.size() - 1);
			ref_lfsr = lfsr_next(ref_lfsr);
			outb = frm[i];
			took = 1'b0;
			want_ext = 1'b0;
			// Bytes past the pattern memory pass untouched
			if (i < PAT_DEPTH) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					pb = ref_data[i][8*l +: 8];
					pf = ref_flags[i][8*l +: 8];
					is_add = pf[FLAG_ADD] | pf[FLAG_ADD_CARRY];
					opnd = pf[FLAG_RANDOM] ? ref_lfsr : pb;
					sum = frm[i] + opnd;
					if (!pf[FLAG_ADD] && pf[FLAG_ADD_CARRY]) begin
						sum = sum + carry[l];
					end
					if (alive[l] && (is_add || pf[FLAG_RANDOM] || pf[FLAG_REPLACE])) begin
						if (is_add) begin
							carry[l] = sum[9:8];
						end
						if (!took) begin
							outb = is_add ? sum[7:0] : opnd;
						end
						took = 1'b1;
					end
					if ((frm[i] != pb && !pf[FLAG_DONT_CARE]) || (pf[FLAG_MUST_LAST] && !last)) begin
						alive[l] = 1'b0;
					end
					want_ext = want_ext | pf[FLAG_EXTRACT];
				end
				if (want_ext && ext_cnt < EXT_BYTES) begin
					ext_buf[8*ext_cnt +: 8] = frm[i];
					ext_cnt++;
				end
			end
			sticky = sticky | took;
			exp_q.push_back({sticky, 1'(i % 3 == 0), last, outb});
		end
		for (int i = 0; i < frm.size(); i++) begin
			@(posedge s_axis_clk);
			match_en <= en;
			s_axis_tvalid <= 1'b1;
			s_axis_tdata <= frm[i];
			s_axis_tuser <= (i % 3 == 0);
			s_axis_tlast <= (i == frm.size() - 1);
		end
		@(posedge s_axis_clk);
		s_axis_tvalid <= 1'b0;
		s_axis_tuser <= 1'b0;
		s_axis_tlast <= 1'b0;
		if ((alive & en) != '0) begin
			exp_match = alive & en;
			exp_id = exp_id + 2'd1;
			exp_ext_num = EXT_NUM_W'(ext_cnt);
			exp_ext_data = ext_buf;
			hit_seen = 1'b1;
		end
		wait_drain();
		repeat (2) @(posedge s_axis_clk);
		check_results();
	endtask

	always @(posedge s_axis_clk) begin
		logic [10:0] want;
		if (rst_n_cdc && m_axis_tvalid) begin
			if (exp_q.size() == 0) begin
				abort_run("Output beat arrived on m_axis with no beat expected");
			end else begin
				want = exp_q.pop_front();
				assert ({m_axis_tuser, m_axis_tlast, m_axis_tdata} == want)
				else abort_run($sformatf("FAIL @ %0t: beat tuser %b last %b data %h, expected %h",
					$time, m_axis_tuser, m_axis_tlast, m_axis_tdata, want));
			end
		end
	end

	always @(posedge s_axis_clk) begin
		if (DUT.u_props.fail_count != 0) begin
			abort_run("A bound stream property of the DUT failed");
		end
	end

	initial begin
		void'($urandom(32'h5177));
		rst_n_cdc = 1'b0;
		s_axis_tdata = 8'h00;
		s_axis_tuser = 1'b0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_data = '0;
		cfg_flags = '0;
		match_en = '0;
		ref_lfsr = LFSR_SEED;
		exp_match = '0;
		exp_id = 2'd0;
		exp_ext_num = '0;
		exp_ext_data = '0;
		hit_seen = 1'b0;
		repeat (8) @(posedge s_axis_clk);
		rst_n_cdc <= 1'b1;
		for (int a = 0; a < PAT_DEPTH; a++) begin
			ref_data[a] = {4{2'b10, 6'(a)}};
			ref_flags[a] = '0;
			write_entry(a);
		end

		// Pass-through
		random_frame(20);
		send_frame(4'b0000);

		// Exact match on lane 0, then near misses
		random_frame(10);
		golden = frm;
		for (int a = 0; a < 10; a++) begin
			set_lane(a, 0, golden[a], (a == 9) ? flag_bit(FLAG_MUST_LAST) : 8'h00);
		end
		send_frame(4'b0001);
		frm[4] = frm[4] ^ 8'h10;
		send_frame(4'b0001);
		frm = golden;
		// Extra byte equals the next entry, so only the last-byte flag rejects it
		frm.push_back(ref_data[10][7:0]);
		send_frame(4'b0001);
		frm = golden;
		send_frame(4'b0010);

		// Replacement, lane 0 wins over lane 1 at position 2
		set_lane(2, 0, 8'hA5, flag_bit(FLAG_DONT_CARE) | flag_bit(FLAG_REPLACE));
		set_lane(4, 0, 8'h00, flag_bit(FLAG_DONT_CARE) | flag_bit(FLAG_RANDOM));
		for (int a = 0; a < 10; a++) begin
			set_lane(a, 1, 8'h3C, flag_bit(FLAG_DONT_CARE) |
				((a == 2 || a == 6) ? flag_bit(FLAG_REPLACE) : 8'h00));
		end
		frm = golden;
		frm[2] = ~frm[2];
		frm[4] = ~frm[4];
		send_frame(4'b0011);

		// Addition with a carry chain on lane 2
		for (int a = 0; a < 10; a++) begin
			set_lane(a, 2, 8'hFF, flag_bit(FLAG_DONT_CARE) |
				((a == 1 || a >= 7) ? flag_bit(FLAG_ADD_CARRY) : 8'h00) |
				((a == 3) ? flag_bit(FLAG_ADD) : 8'h00));
		end
		random_frame(10);
		send_frame(4'b0100);
		random_frame(10);
		send_frame(4'b0100);

		// Extraction on lane 3, then saturation
		for (int a = 0; a < PAT_DEPTH; a++) begin
			set_lane(a, 3, 8'h00, flag_bit(FLAG_DONT_CARE) |
				((a >= 10 && a < 30) ? flag_bit(FLAG_EXTRACT) : 8'h00));
		end
		random_frame(14);
		send_frame(4'b1000);
		random_frame(40);
		send_frame(4'b1000);

		// Frame longer than the pattern memory
		set_lane(PAT_DEPTH - 1, 3, 8'h5A, flag_bit(FLAG_REPLACE));
		random_frame(70);
		frm[PAT_DEPTH - 1] = 8'h5A;
		send_frame(4'b1000);

		repeat (4) @(posedge s_axis_clk);
		if (DUT.u_props.fail_count == 0 && exp_q.size() == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			abort_run("Property failure or missing output beats at the end of the run");
		end
	end

endmodule

// File: hdl/byte_rewriter.sv
// Output stage of the matcher: LFSR, lane priority mux and registered m_axis stream
`timescale 1ns/10ps

module byte_rewriter
	import efm_geom_pkg::*;
(
	input  logic                 s_axis_clk,
	input  logic                 rst_n_cdc,
	input  logic                 s_axis_tvalid,
	input  logic [7:0]           byte_data,
	input  logic                 byte_user,
	input  logic                 byte_last,
	input  logic                 byte_valid,
	input  logic                 frame_end,
	input  logic [NUM_LANES-1:0] mod_req,
	input  logic [PAT_W-1:0]     mod_bytes,
	output logic [7:0]           lfsr_val,
	output logic [7:0]           m_axis_tdata,
	output logic [1:0]           m_axis_tuser,
	output logic                 m_axis_tlast,
	output logic                 m_axis_tvalid
);

	logic [7:0] out_byte;
	logic feedback;

	// Fibonacci taps 7 5 4 3, one step per input beat
	assign feedback = lfsr_val[7] ^ lfsr_val[5] ^ lfsr_val[4] ^ lfsr_val[3];

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			lfsr_val <= LFSR_SEED;
		end else if (s_axis_tvalid) begin
			lfsr_val <= {lfsr_val[6:0], feedback};
		end
	end

	// Lowest lane wins, so scan downwards
	always_comb begin
		out_byte = byte_data;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (mod_req[i]) begin
				out_byte = mod_bytes[8*i +: 8];
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			m_axis_tvalid <= 1'b0;
			m_axis_tlast <= 1'b0;
			m_axis_tuser <= 2'b00;
		end else begin
			m_axis_tvalid <= byte_valid;
			m_axis_tlast <= byte_last;
			m_axis_tuser[0] <= byte_user;
			// Modified flag holds until the frame is over
			m_axis_tuser[1] <= (m_axis_tuser[1] | (|mod_req)) & ~frame_end;
		end
	end

	always_ff @(posedge s_axis_clk) begin
		m_axis_tdata <= out_byte;
	end

endmodule

// File: hdl/efm_geom_pkg.sv
// Memory geometry, lane count, flag bit positions and extraction limits of the frame matcher
package efm_geom_pkg;

	// Pattern memory, one byte per lane in each entry
	localparam int NUM_LANES = 4;
	localparam int PAT_DEPTH = 64;
	localparam int PAT_AW = 6;
	localparam int PAT_W = 8 * NUM_LANES;

	// Bit positions inside a lane flag byte
	localparam int FLAG_DONT_CARE = 0;
	localparam int FLAG_MUST_LAST = 1;
	localparam int FLAG_REPLACE = 2;
	localparam int FLAG_RANDOM = 3;
	localparam int FLAG_EXTRACT = 4;
	localparam int FLAG_ADD = 5;
	localparam int FLAG_ADD_CARRY = 6;

	// Extracted field
	localparam int EXT_BYTES = 16;
	localparam int EXT_NUM_W = 5;
	localparam int EXT_DATA_W = 8 * EXT_BYTES;

	localparam logic [7:0] LFSR_SEED = 8'h0B;

endpackage

// File: hdl/efm_op_pkg.sv
// Lane opcode and frame state types, imported by the lane engines and the frame control
package efm_op_pkg;

	// Operation a lane applies to the current byte
	// Addition wins over replacement when both flags are set
	typedef enum logic [2:0] {
		op_none,
		op_replace,
		op_replace_rand,
		op_add,
		op_add_rand,
		op_add_carry,
		op_add_carry_rand
	} lane_op_e;

	// Where the input stream is within a frame
	// fs_overrun: frame is longer than the pattern memory
	typedef enum logic [1:0] {
		fs_idle,
		fs_in_frame,
		fs_overrun
	} frame_state_e;

endpackage

// File: hdl/eth_frame_matcher.sv
// Top level of the Ethernet frame matcher: control, pattern memory, four lanes, extractor, rewriter
`timescale 1ns/10ps

module eth_frame_matcher
	import efm_geom_pkg::*;
(
	input  logic                  s_axis_clk,
	input  logic                  rst_n_cdc,
	input  logic [7:0]            s_axis_tdata,
	input  logic                  s_axis_tuser,
	input  logic                  s_axis_tlast,
	input  logic                  s_axis_tvalid,
	output logic [7:0]            m_axis_tdata,
	output logic [1:0]            m_axis_tuser,
	output logic                  m_axis_tlast,
	output logic                  m_axis_tvalid,
	input  logic                  cfg_we,
	input  logic [PAT_AW-1:0]     cfg_addr,
	input  logic [PAT_W-1:0]      cfg_data,
	input  logic [PAT_W-1:0]      cfg_flags,
	input  logic [NUM_LANES-1:0]  match_en,
	output logic [NUM_LANES-1:0]  match,
	output logic [1:0]            match_id,
	output logic [EXT_NUM_W-1:0]  match_ext_num,
	output logic [EXT_DATA_W-1:0] match_ext_data
);

	logic [PAT_AW-1:0] pattern_addr;
	logic [PAT_W-1:0] pat_data;
	logic [PAT_W-1:0] pat_flags;
	logic [7:0] byte_data;
	logic byte_user;
	logic byte_last;
	logic byte_valid;
	logic byte_active;
	logic frame_end;
	logic [NUM_LANES-1:0] lane_match;
	logic [NUM_LANES-1:0] mod_req;
	logic [PAT_W-1:0] mod_bytes;
	logic [NUM_LANES-1:0] extract_flags;
	logic [7:0] lfsr_val;
	logic [EXT_NUM_W-1:0] ext_num;
	logic [EXT_DATA_W-1:0] ext_data;

	frame_ctrl u_ctrl (
		.s_axis_clk     (s_axis_clk),
		.rst_n_cdc      (rst_n_cdc),
		.s_axis_tdata   (s_axis_tdata),
		.s_axis_tuser   (s_axis_tuser),
		.s_axis_tlast   (s_axis_tlast),
		.s_axis_tvalid  (s_axis_tvalid),
		.match_en       (match_en),
		.lane_match     (lane_match),
		.ext_num        (ext_num),
		.ext_data       (ext_data),
		.pattern_addr   (pattern_addr),
		.byte_data      (byte_data),
		.byte_user      (byte_user),
		.byte_last      (byte_last),
		.byte_valid     (byte_valid),
		.byte_active    (byte_active),
		.frame_end      (frame_end),
		.match          (match),
		.match_id       (match_id),
		.match_ext_num  (match_ext_num),
		.match_ext_data (match_ext_data)
	);

	pattern_ram u_ram (
		.s_axis_clk   (s_axis_clk),
		.cfg_we       (cfg_we),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.cfg_flags    (cfg_flags),
		.pattern_addr (pattern_addr),
		.pat_data     (pat_data),
		.pat_flags    (pat_flags)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_engine u_lane (
			.s_axis_clk  (s_axis_clk),
			.rst_n_cdc   (rst_n_cdc),
			.byte_active (byte_active),
			.frame_end   (frame_end),
			.byte_data   (byte_data),
			.byte_last   (byte_last),
			.pat_byte    (pat_data[8*i +: 8]),
			.pat_flags   (pat_flags[8*i +: 8]),
			.lfsr_val    (lfsr_val),
			.lane_match  (lane_match[i]),
			.mod_req     (mod_req[i]),
			.mod_byte    (mod_bytes[8*i +: 8])
		);

		assign extract_flags[i] = pat_flags[8*i + FLAG_EXTRACT];
	end

	field_extractor u_ext (
		.s_axis_clk    (s_axis_clk),
		.rst_n_cdc     (rst_n_cdc),
		.byte_active   (byte_active),
		.frame_end     (frame_end),
		.byte_data     (byte_data),
		.extract_flags (extract_flags),
		.ext_num       (ext_num),
		.ext_data      (ext_data)
	);

	byte_rewriter u_rewr (
		.s_axis_clk    (s_axis_clk),
		.rst_n_cdc     (rst_n_cdc),
		.s_axis_tvalid (s_axis_tvalid),
		.byte_data     (byte_data),
		.byte_user     (byte_user),
		.byte_last     (byte_last),
		.byte_valid    (byte_valid),
		.frame_end     (frame_end),
		.mod_req       (mod_req),
		.mod_bytes     (mod_bytes),
		.lfsr_val      (lfsr_val),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid)
	);

endmodule

// File: hdl/field_extractor.sv
// Field extractor: collects the flagged bytes of a frame into a 16-byte field with a count
`timescale 1ns/10ps

module field_extractor
	import efm_geom_pkg::*;
(
	input  logic                  s_axis_clk,
	input  logic                  rst_n_cdc,
	input  logic                  byte_active,
	input  logic                  frame_end,
	input  logic [7:0]            byte_data,
	input  logic [NUM_LANES-1:0]  extract_flags,
	output logic [EXT_NUM_W-1:0]  ext_num,
	output logic [EXT_DATA_W-1:0] ext_data
);

	logic take;
	logic full;

	// Any lane may ask for a byte, matching or not
	assign take = byte_active & (|extract_flags);
	assign full = (ext_num == EXT_NUM_W'(EXT_BYTES));

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc || frame_end) begin
			ext_num <= '0;
			ext_data <= '0;
		end else if (take && !full) begin
			// Slot order follows byte order in the frame
			ext_data[8*ext_num[EXT_NUM_W-2:0] +: 8] <= byte_data;
			ext_num <= ext_num + 1'b1;
		end
	end

endmodule

// File: hdl/frame_ctrl.sv
// Frame control of the matcher: input register, frame FSM, pattern address and match results
`timescale 1ns/10ps

module frame_ctrl
	import efm_geom_pkg::*;
	import efm_op_pkg::*;
(
	input  logic                  s_axis_clk,
	input  logic                  rst_n_cdc,
	input  logic [7:0]            s_axis_tdata,
	input  logic                  s_axis_tuser,
	input  logic                  s_axis_tlast,
	input  logic                  s_axis_tvalid,
	input  logic [NUM_LANES-1:0]  match_en,
	input  logic [NUM_LANES-1:0]  lane_match,
	input  logic [EXT_NUM_W-1:0]  ext_num,
	input  logic [EXT_DATA_W-1:0] ext_data,
	output logic [PAT_AW-1:0]     pattern_addr,
	output logic [7:0]            byte_data,
	output logic                  byte_user,
	output logic                  byte_last,
	output logic                  byte_valid,
	output logic                  byte_active,
	output logic                  frame_end,
	output logic [NUM_LANES-1:0]  match,
	output logic [1:0]            match_id,
	output logic [EXT_NUM_W-1:0]  match_ext_num,
	output logic [EXT_DATA_W-1:0] match_ext_data
);

	frame_state_e state;
	logic byte_ovr;
	logic [NUM_LANES-1:0] hit;

	assign hit = lane_match & match_en;

	// Beat count within the frame, used as pattern read address
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			pattern_addr <= '0;
		end else if (s_axis_tvalid) begin
			if (s_axis_tlast) begin
				pattern_addr <= '0;
			end else if (pattern_addr != PAT_AW'(PAT_DEPTH - 1)) begin
				pattern_addr <= pattern_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			state <= fs_idle;
		end else if (s_axis_tvalid) begin
			if (s_axis_tlast) begin
				state <= fs_idle;
			end else if (pattern_addr == PAT_AW'(PAT_DEPTH - 1)) begin
				state <= fs_overrun;
			end else if (state == fs_idle) begin
				state <= fs_in_frame;
			end
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			byte_valid <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			byte_valid <= s_axis_tvalid;
			frame_end <= byte_valid & byte_last;
		end
	end

	// Beat payload, with the frame state it was sampled in
	always_ff @(posedge s_axis_clk) begin
		byte_data <= s_axis_tdata;
		byte_user <= s_axis_tuser;
		byte_last <= s_axis_tlast;
		byte_ovr <= (state == fs_overrun);
	end

	// Bytes past the last pattern entry are left alone
	assign byte_active = byte_valid & ~byte_ovr;

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc) begin
			match <= '0;
			match_id <= 2'd0;
			match_ext_num <= '0;
		end else if (frame_end && hit != '0) begin
			match <= hit;
			match_id <= match_id + 2'd1;
			match_ext_num <= ext_num;
		end
	end

	always_ff @(posedge s_axis_clk) begin
		if (frame_end && hit != '0) begin
			match_ext_data <= ext_data;
		end
	end

endmodule

// File: hdl/lane_engine.sv
// One pattern lane: match tracking, opcode decode, byte replacement and carry-chained addition
`timescale 1ns/10ps

module lane_engine
	import efm_geom_pkg::*;
	import efm_op_pkg::*;
(
	input  logic       s_axis_clk,
	input  logic       rst_n_cdc,
	input  logic       byte_active,
	input  logic       frame_end,
	input  logic [7:0] byte_data,
	input  logic       byte_last,
	input  logic [7:0] pat_byte,
	input  logic [7:0] pat_flags,
	input  logic [7:0] lfsr_val,
	output logic       lane_match,
	output logic       mod_req,
	output logic [7:0] mod_byte
);

	lane_op_e op;
	logic [7:0] operand;
	logic [1:0] carry;
	logic [1:0] carry_in;
	logic [9:0] sum;
	logic is_add;

	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc || frame_end) begin
			lane_match <= 1'b1;
		end else if (byte_active) begin
			if (byte_data != pat_byte && !pat_flags[FLAG_DONT_CARE]) begin
				lane_match <= 1'b0;
			end
			if (pat_flags[FLAG_MUST_LAST] && !byte_last) begin
				lane_match <= 1'b0;
			end
		end
	end

	// Only a lane that still matches may touch the byte
	always_comb begin
		op = op_none;
		if (byte_active && lane_match) begin
			if (pat_flags[FLAG_ADD]) begin
				op = pat_flags[FLAG_RANDOM] ? op_add_rand : op_add;
			end else if (pat_flags[FLAG_ADD_CARRY]) begin
				op = pat_flags[FLAG_RANDOM] ? op_add_carry_rand : op_add_carry;
			end else if (pat_flags[FLAG_RANDOM]) begin
				op = op_replace_rand;
			end else if (pat_flags[FLAG_REPLACE]) begin
				op = op_replace;
			end
		end
	end

	assign operand = (op inside {op_replace_rand, op_add_rand, op_add_carry_rand}) ?
		lfsr_val : pat_byte;
	assign is_add = op inside {op_add, op_add_rand, op_add_carry, op_add_carry_rand};
	assign carry_in = (op inside {op_add_carry, op_add_carry_rand}) ? carry : 2'b00;
	assign sum = {2'b00, byte_data} + {2'b00, operand} + {8'h00, carry_in};

	assign mod_req = (op != op_none);
	assign mod_byte = is_add ? sum[7:0] : operand;

	// Carry out of the last addition in this frame
	always_ff @(posedge s_axis_clk) begin
		if (!rst_n_cdc || frame_end) begin
			carry <= 2'b00;
		end else if (is_add) begin
			carry <= sum[9:8];
		end
	end

endmodule

// File: hdl/pattern_ram.sv
// Pattern memory of the matcher: byte and flag per lane per position, one-cycle registered read
`timescale 1ns/10ps

module pattern_ram
	import efm_geom_pkg::*;
(
	input  logic              s_axis_clk,
	input  logic              cfg_we,
	input  logic [PAT_AW-1:0] cfg_addr,
	input  logic [PAT_W-1:0]  cfg_data,
	input  logic [PAT_W-1:0]  cfg_flags,
	input  logic [PAT_AW-1:0] pattern_addr,
	output logic [PAT_W-1:0]  pat_data,
	output logic [PAT_W-1:0]  pat_flags
);

	// Flags in the upper half, pattern bytes in the lower half
	// Lane n sits at bits 8n+7:8n of each half
	logic [2*PAT_W-1:0] mem [PAT_DEPTH];

	always_ff @(posedge s_axis_clk) begin
		if (cfg_we) begin
			mem[cfg_addr] <= {cfg_flags, cfg_data};
		end
	end

	// Read lines up with the registered beat in frame_ctrl
	always_ff @(posedge s_axis_clk) begin
		{pat_flags, pat_data} <= mem[pattern_addr];
	end

endmodule

// File: verilog.f
hdl/efm_geom_pkg.sv
hdl/efm_op_pkg.sv
hdl/frame_ctrl.sv
hdl/pattern_ram.sv
hdl/lane_engine.sv
hdl/field_extractor.sv
hdl/byte_rewriter.sv
hdl/eth_frame_matcher.sv
dv/eth_frame_matcher_props.sv
dv/tb_eth_frame_matcher.sv
